// File: hdl/sd_pkg.sv
// ==================================================
// sd_pkg: shared types and constants for the SPI
// mode SD sector reader
// ==================================================
package sd_pkg;

  typedef logic [7:0]  byte_t;       // one spi or data byte
  typedef logic [31:0] sector_t;     // block address, cmd17 argument
  typedef logic [8:0]  buf_index_t;  // buffer position, wraps at 512

  // host command encoding
  typedef enum logic [1:0] {
    cmd_idle = 2'd0,  // nothing to do
    cmd_read = 2'd1,  // start a sector read
    cmd_next = 2'd2   // step the read index
  } sd_cmd_e;

  localparam int sector_bytes = 512;
  localparam int spi_clk_div  = 4;  // log2 of clk cycles per sclk half-period

  // init sequence
  localparam int init_dummy_bytes = 10;  // >= 74 clocks with cs high
  localparam int resp_poll_limit  = 16;  // fill bytes tolerated before r1

  // sd command indices
  localparam logic [5:0] sd_idx_cmd0   = 6'd0;   // go idle
  localparam logic [5:0] sd_idx_cmd17  = 6'd17;  // read single block
  localparam logic [5:0] sd_idx_cmd55  = 6'd55;  // app command prefix
  localparam logic [5:0] sd_idx_acmd41 = 6'd41;  // send op cond

  // frame and response bytes
  localparam byte_t   crc_cmd0    = 8'h95;          // valid crc for cmd0 only
  localparam byte_t   crc_dummy   = 8'h01;          // end bit set, crc ignored in spi mode
  localparam byte_t   fill_byte   = 8'hFF;          // mosi idle / poll byte
  localparam byte_t   token_start = 8'hFE;          // start of data block
  localparam byte_t   r1_idle     = 8'h01;
  localparam byte_t   r1_ready    = 8'h00;
  localparam sector_t acmd41_arg  = 32'h4000_0000;  // hcs bit, host takes sdhc

endpackage

// File: hdl/sd_cmd_decode.sv
// ==================================================
// sd_cmd_decode: host command decoder, sequences
// card init, idle and sector reads
// ==================================================
`timescale 1ns/1ps

module sd_cmd_decode (
  input  logic              clk,
  input  logic              rst_n,
  input  sd_pkg::sd_cmd_e   command,
  input  sd_pkg::sector_t   sector,
  output logic              busy,
  output logic              read_error,
  output logic              start_init,
  output logic              start_read,
  output sd_pkg::sector_t   read_sector,
  input  logic              engine_ready,
  input  logic              engine_fail,
  output logic              index_clear,
  output logic              index_step
);
  import sd_pkg::*;

  typedef enum logic [1:0] {
    st_init,  // card bring-up running
    st_idle,  // accepting host commands
    st_read   // cmd17 in progress
  } state_e;

  state_e state;
  logic   launched;  // start_init already sent for this attempt

  assign busy = (state != st_idle);

  // index control goes straight to the buffer so data_out moves one cycle later
  assign index_clear = (state == st_idle) && (command == cmd_read);
  assign index_step  = (state == st_idle) && (command == cmd_next);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= st_init;
      launched   <= 1'b0;
      start_init <= 1'b0;
      start_read <= 1'b0;
      read_error <= 1'b0;
    end else begin
      start_init <= 1'b0;  // single-cycle pulses
      start_read <= 1'b0;
      case (state)
        st_init: begin
          if (!launched) begin
            if (engine_ready) begin
              start_init <= 1'b1;
              launched   <= 1'b1;
            end
          end else if (engine_ready && !start_init) begin
            // engine ready still high in the pulse cycle, so skip that one
            if (engine_fail) begin
              launched <= 1'b0;  // retry the whole init
            end else begin
              state <= st_idle;
            end
          end
        end
        st_idle: begin
          if (command == cmd_read) begin
            start_read <= 1'b1;
            read_error <= 1'b0;  // sticky flag cleared by a new read
            state      <= st_read;
          end
        end
        st_read: begin
          if (engine_ready && !start_read) begin
            read_error <= engine_fail;  // fail pulses together with ready
            state      <= st_idle;
          end
        end
        default: state <= st_init;
      endcase
    end
  end

  // sector latch, held for the whole read
  always_ff @(posedge clk) begin
    if (state == st_idle && command == cmd_read) begin
      read_sector <= sector;
    end
  end

endmodule

// File: hdl/sd_spi_engine.sv
// ==================================================
// sd_spi_engine: spi mode 0 byte engine and command
// sequencer for card init and single block reads
// ==================================================
`timescale 1ns/1ps

module sd_spi_engine #(
  parameter int clk_div = sd_pkg::spi_clk_div
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start_init,
  input  logic              start_read,
  input  sd_pkg::sector_t   read_sector,
  output logic              engine_ready,
  output logic              engine_fail,
  output logic              byte_valid,
  output sd_pkg::byte_t     byte_data,
  output logic              sd_cs_n,
  output logic              sd_clk,
  output logic              sd_mosi,
  input  logic              sd_miso
);
  import sd_pkg::*;

  localparam int div_w = (clk_div == 0) ? 1 : clk_div;

  typedef enum logic [2:0] {
    s_idle,   // waiting for a start
    s_dummy,  // init clocks, cs high
    s_frame,  // six byte command frame
    s_poll,   // waiting for r1
    s_token,  // waiting for data start token
    s_data,   // 512 payload bytes
    s_crc     // two crc bytes, dropped
  } state_e;

  // slow clock tick, one per sclk half-period
  logic [div_w-1:0] div_cnt;
  logic             tick;

  // byte shifter
  logic       xfer_go;    // load tx_byte and start shifting
  logic       xfer_done;  // rx_byte valid, one cycle
  byte_t      tx_byte;
  byte_t      tx_sr;
  byte_t      rx_byte;
  logic [2:0] bit_cnt;
  logic       shifting;

  // sequencer
  state_e     state;
  logic [5:0] cmd_idx;    // command currently in flight
  logic [2:0] frame_pos;  // byte within the frame
  logic [4:0] cnt;        // dummy / poll / crc counter
  buf_index_t data_cnt;

  // argument field for each command
  function automatic sector_t cmd_arg(input logic [5:0] idx, input sector_t sec);
    sector_t arg;
    arg = '0;
    if (idx == sd_idx_cmd17) arg = sec;
    else if (idx == sd_idx_acmd41) arg = acmd41_arg;
    return arg;
  endfunction

  // frame byte at position pos: start+index, arg msb first, crc
  function automatic byte_t frame_byte(input logic [5:0] idx, input logic [2:0] pos,
                                       input sector_t sec);
    sector_t arg;
    byte_t   b;
    arg = cmd_arg(idx, sec);
    case (pos)
      3'd0:    b = {2'b01, idx};
      3'd1:    b = arg[31:24];
      3'd2:    b = arg[23:16];
      3'd3:    b = arg[15:8];
      3'd4:    b = arg[7:0];
      default: b = (idx == sd_idx_cmd0) ? crc_cmd0 : crc_dummy;
    endcase
    return b;
  endfunction

  assign tick         = (clk_div == 0) ? 1'b1 : (div_cnt == '0);
  assign engine_ready = (state == s_idle);

  always_ff @(posedge clk) begin
    if (!rst_n) div_cnt <= '0;
    else        div_cnt <= div_cnt + 1'b1;  // free running
  end

  // full duplex shifter, mode 0: sample on rise, shift after fall
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      shifting  <= 1'b0;
      xfer_done <= 1'b0;
      sd_clk    <= 1'b0;
      sd_mosi   <= 1'b1;
      bit_cnt   <= '0;
      tx_sr     <= fill_byte;
      rx_byte   <= fill_byte;
    end else begin
      xfer_done <= 1'b0;
      if (xfer_go) begin
        tx_sr    <= tx_byte;
        sd_mosi  <= tx_byte[7];  // msb ready before first rise
        bit_cnt  <= '0;
        shifting <= 1'b1;
      end else if (shifting && tick) begin
        if (!sd_clk) begin
          sd_clk  <= 1'b1;
          rx_byte <= {rx_byte[6:0], sd_miso};
        end else begin
          sd_clk <= 1'b0;
          if (bit_cnt == 3'd7) begin
            shifting  <= 1'b0;
            xfer_done <= 1'b1;
            sd_mosi   <= 1'b1;  // idle high between bytes
          end else begin
            tx_sr   <= {tx_sr[6:0], 1'b0};
            sd_mosi <= tx_sr[6];
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
      end
    end
  end

  // command sequencer, acts on start and on each finished byte
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= s_idle;
      sd_cs_n     <= 1'b1;
      xfer_go     <= 1'b0;
      tx_byte     <= fill_byte;
      byte_valid  <= 1'b0;
      engine_fail <= 1'b0;
      cmd_idx     <= sd_idx_cmd0;
      frame_pos   <= '0;
      cnt         <= '0;
      data_cnt    <= '0;
    end else begin
      xfer_go     <= 1'b0;
      byte_valid  <= 1'b0;
      engine_fail <= 1'b0;
      case (state)
        s_idle: begin
          if (start_init) begin
            cnt     <= '0;
            tx_byte <= fill_byte;
            xfer_go <= 1'b1;
            state   <= s_dummy;   // cs stays high
          end else if (start_read) begin
            sd_cs_n   <= 1'b0;
            cmd_idx   <= sd_idx_cmd17;
            frame_pos <= '0;
            tx_byte   <= frame_byte(sd_idx_cmd17, 3'd0, read_sector);
            xfer_go   <= 1'b1;
            state     <= s_frame;
          end
        end
        s_dummy: if (xfer_done) begin
          xfer_go <= 1'b1;
          if (cnt == 5'(init_dummy_bytes - 1)) begin
            sd_cs_n   <= 1'b0;
            cmd_idx   <= sd_idx_cmd0;
            frame_pos <= '0;
            tx_byte   <= frame_byte(sd_idx_cmd0, 3'd0, read_sector);
            state     <= s_frame;
          end else begin
            cnt     <= cnt + 1'b1;
            tx_byte <= fill_byte;
          end
        end
        s_frame: if (xfer_done) begin
          xfer_go <= 1'b1;
          if (frame_pos == 3'd5) begin
            cnt     <= '0;
            tx_byte <= fill_byte;
            state   <= s_poll;
          end else begin
            frame_pos <= frame_pos + 1'b1;
            tx_byte   <= frame_byte(cmd_idx, frame_pos + 3'd1, read_sector);
          end
        end
        s_poll: if (xfer_done) begin
          if (rx_byte != fill_byte) begin
            frame_pos <= '0;
            if (cmd_idx == sd_idx_cmd0 && rx_byte == r1_idle) begin
              cmd_idx <= sd_idx_cmd55;
              tx_byte <= frame_byte(sd_idx_cmd55, 3'd0, read_sector);
              xfer_go <= 1'b1;
              state   <= s_frame;
            end else if (cmd_idx == sd_idx_cmd55) begin
              cmd_idx <= sd_idx_acmd41;  // prefix done, send the app command
              tx_byte <= frame_byte(sd_idx_acmd41, 3'd0, read_sector);
              xfer_go <= 1'b1;
              state   <= s_frame;
            end else if (cmd_idx == sd_idx_acmd41) begin
              if (rx_byte == r1_ready) begin
                sd_cs_n <= 1'b1;  // card out of idle, init done
                state   <= s_idle;
              end else begin
                cmd_idx <= sd_idx_cmd55;
                tx_byte <= frame_byte(sd_idx_cmd55, 3'd0, read_sector);
                xfer_go <= 1'b1;
                state   <= s_frame;
              end
            end else if (cmd_idx == sd_idx_cmd17 && rx_byte == r1_ready) begin
              tx_byte <= fill_byte;
              xfer_go <= 1'b1;
              state   <= s_token;
            end else begin
              engine_fail <= 1'b1;  // rejected command
              sd_cs_n     <= 1'b1;
              state       <= s_idle;
            end
          end else if (cnt == 5'(resp_poll_limit - 1)) begin
            engine_fail <= 1'b1;  // no response
            sd_cs_n     <= 1'b1;
            state       <= s_idle;
          end else begin
            cnt     <= cnt + 1'b1;
            tx_byte <= fill_byte;
            xfer_go <= 1'b1;
          end
        end
        s_token: if (xfer_done) begin
          tx_byte <= fill_byte;
          xfer_go <= 1'b1;
          if (rx_byte == token_start) begin
            data_cnt <= '0;
            state    <= s_data;
          end
        end
        s_data: if (xfer_done) begin
          byte_valid <= 1'b1;
          tx_byte    <= fill_byte;
          xfer_go    <= 1'b1;
          if (data_cnt == buf_index_t'(sector_bytes - 1)) begin
            cnt   <= '0;
            state <= s_crc;
          end else begin
            data_cnt <= data_cnt + 1'b1;
          end
        end
        s_crc: if (xfer_done) begin
          if (cnt == 5'd1) begin
            sd_cs_n <= 1'b1;
            state   <= s_idle;
          end else begin
            cnt     <= cnt + 1'b1;
            tx_byte <= fill_byte;
            xfer_go <= 1'b1;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  // payload byte towards the buffer
  always_ff @(posedge clk) begin
    if (state == s_data && xfer_done) byte_data <= rx_byte;
  end

endmodule

// File: hdl/sd_sector_buffer.sv
// ==================================================
// sd_sector_buffer: 512 byte sector store, one index
// shared by card fill and host readout
// ==================================================
`timescale 1ns/1ps

module sd_sector_buffer (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            byte_valid,
  input  sd_pkg::byte_t   byte_data,
  input  logic            index_clear,
  input  logic            index_step,
  output sd_pkg::byte_t   data_out
);
  import sd_pkg::*;

  byte_t      mem [sector_bytes];
  buf_index_t index;  // wraps to 0 after a full sector

  // fill path
  always_ff @(posedge clk) begin
    if (byte_valid) begin
      mem[index] <= byte_data;
    end
  end

  // the engine and the host never step in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      index <= '0;
    end else if (index_clear) begin
      index <= '0;  // new read
    end else if (byte_valid || index_step) begin
      index <= index + 1'b1;
    end
  end

  assign data_out = mem[index];  // no output register

endmodule

// File: hdl/sdcard.sv
// ==================================================
// sdcard: spi mode sd sector reader, host side
// command port plus card pins
// ==================================================
`timescale 1ns/1ps

module sdcard #(
  parameter int clk_div = sd_pkg::spi_clk_div
) (
  input  logic              clk,
  input  logic              rst_n,
  input  sd_pkg::sd_cmd_e   command,
  input  sd_pkg::sector_t   sector,
  output sd_pkg::byte_t     data_out,
  output logic              busy,
  output logic              read_error,
  output logic              sd_cs_n,
  output logic              sd_clk,
  output logic              sd_mosi,
  input  logic              sd_miso
);
  import sd_pkg::*;

  logic    start_init;
  logic    start_read;
  sector_t read_sector;
  logic    engine_ready;
  logic    engine_fail;
  logic    index_clear;
  logic    index_step;
  logic    byte_valid;
  byte_t   byte_data;

  sd_cmd_decode decode_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .command      (command),
    .sector       (sector),
    .busy         (busy),
    .read_error   (read_error),
    .start_init   (start_init),
    .start_read   (start_read),
    .read_sector  (read_sector),
    .engine_ready (engine_ready),
    .engine_fail  (engine_fail),
    .index_clear  (index_clear),
    .index_step   (index_step)
  );

  sd_spi_engine #(.clk_div(clk_div)) engine_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_init   (start_init),
    .start_read   (start_read),
    .read_sector  (read_sector),
    .engine_ready (engine_ready),
    .engine_fail  (engine_fail),
    .byte_valid   (byte_valid),
    .byte_data    (byte_data),
    .sd_cs_n      (sd_cs_n),
    .sd_clk       (sd_clk),
    .sd_mosi      (sd_mosi),
    .sd_miso      (sd_miso)
  );

  sd_sector_buffer buffer_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .byte_valid  (byte_valid),
    .byte_data   (byte_data),
    .index_clear (index_clear),
    .index_step  (index_step),
    .data_out    (data_out)
  );

endmodule

// File: tb/sd_card_model.sv
// ==================================================
// sd_card_model: behavioural spi mode sd card,
// answers init commands and cmd17 with patterned data
// ==================================================
`timescale 1ns/1ps

module sd_card_model (
  input  logic sd_cs_n,
  input  logic sd_clk,
  input  logic sd_mosi,
  output logic sd_miso
);
  import sd_pkg::*;

  byte_t rx_sr = fill_byte;
  byte_t tx_sr = fill_byte;  // bit 7 drives miso
  int    bit_cnt = 0;
  logic  byte_end = 1'b0;    // a byte just closed, load the next on the fall
  byte_t frame [6];
  int    frame_pos = 0;      // 0 means waiting for a start byte
  logic  in_idle = 1'b1;
  logic  app_cmd = 1'b0;     // previous command was cmd55
  int    acmd41_count = 0;
  byte_t out_q [$];          // bytes waiting for miso

  assign sd_miso = sd_cs_n ? 1'b1 : tx_sr[7];

  // one fill byte of ncr, then r1
  task automatic queue_r1(input byte_t r1);
    out_q.push_back(fill_byte);
    out_q.push_back(r1);
  endtask

  task automatic respond();
    logic [5:0] idx;
    sector_t    arg;
    idx = frame[0][5:0];
    arg = {frame[1], frame[2], frame[3], frame[4]};
    if (idx == sd_idx_cmd0) begin
      in_idle      = 1'b1;
      app_cmd      = 1'b0;
      acmd41_count = 0;
      queue_r1(r1_idle);
    end else if (idx == sd_idx_cmd55) begin
      app_cmd = 1'b1;
      queue_r1(in_idle ? r1_idle : r1_ready);
    end else if (idx == sd_idx_acmd41 && app_cmd) begin
      app_cmd = 1'b0;
      if (acmd41_count < 2) begin
        acmd41_count = acmd41_count + 1;  // still powering up
        queue_r1(r1_idle);
      end else begin
        in_idle = 1'b0;
        queue_r1(r1_ready);
      end
    end else if (idx == sd_idx_cmd17) begin
      app_cmd = 1'b0;
      if (arg >= 32'h0100_0000) begin
        queue_r1(8'h20);  // address error, no data follows
      end else begin
        queue_r1(r1_ready);
        out_q.push_back(fill_byte);  // access time
        out_q.push_back(token_start);
        for (int i = 0; i < sector_bytes; i++) begin
          out_q.push_back((arg[7:0] + 8'(i)) ^ 8'h5A);
        end
        out_q.push_back(8'hC3);  // crc bytes, never checked
        out_q.push_back(8'h3C);
      end
    end else begin
      app_cmd = 1'b0;
      queue_r1(8'h04);  // illegal command
    end
  endtask

  // collects six byte frames, start byte is 01xxxxxx
  task automatic take_byte(input byte_t b);
    if (frame_pos == 0) begin
      if (b[7:6] == 2'b01) begin
        frame[0]  = b;
        frame_pos = 1;
      end
    end else begin
      frame[frame_pos] = b;
      frame_pos        = frame_pos + 1;
      if (frame_pos == 6) begin
        frame_pos = 0;
        respond();
      end
    end
  endtask

  // mode 0: sample mosi on the rise, move miso on the fall
  always @(posedge sd_clk or negedge sd_clk or posedge sd_cs_n) begin
    if (sd_cs_n) begin
      bit_cnt   = 0;  // deselected, dummy clocks are ignored
      byte_end  = 1'b0;
      frame_pos = 0;
      tx_sr     = fill_byte;
      out_q.delete();
    end else if (sd_clk) begin
      rx_sr   = {rx_sr[6:0], sd_mosi};
      bit_cnt = bit_cnt + 1;
      if (bit_cnt == 8) begin
        bit_cnt  = 0;
        byte_end = 1'b1;
        take_byte(rx_sr);
      end
    end else if (byte_end) begin
      byte_end = 1'b0;
      if (out_q.size() > 0) tx_sr = out_q.pop_front();
      else                  tx_sr = fill_byte;
    end else begin
      tx_sr = {tx_sr[6:0], 1'b1};
    end
  end

endmodule

// File: tb/sdcard_checker.sv
// ==================================================
// sdcard_checker: handshake and chip select rules,
// bound into the sector reader top level
// ==================================================
`timescale 1ns/1ps

module sdcard_checker (
  input logic            clk,
  input logic            rst_n,
  input sd_pkg::sd_cmd_e command,
  input logic            busy,
  input logic            sd_cs_n,
  input logic            sd_clk
);
  import sd_pkg::*;

  int   fail_count = 0;  // polled by the testbench at the end
  logic init_done;       // busy has fallen once since reset

  always_ff @(posedge clk) begin
    if (!rst_n) init_done <= 1'b0;
    else if (!busy) init_done <= 1'b1;
  end

  // card deselected whenever the host side is idle
  cs_high_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !busy |-> sd_cs_n)
    else begin
      fail_count = fail_count + 1;
      $error("chip select active while busy is low");
    end

  read_raises_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (command == cmd_read && !busy) |=> busy)
    else begin
      fail_count = fail_count + 1;
      $error("accepted read did not raise busy");
    end

  // dummy init clocks run with cs high, so only after init
  clk_low_when_deselected: assert property (@(posedge clk) disable iff (!rst_n)
    (init_done && sd_cs_n) |-> !sd_clk)
    else begin
      fail_count = fail_count + 1;
      $error("spi clock active while card deselected");
    end

endmodule

// File: tb/sdcard_tb.sv
// ==================================================
// sdcard_tb drives init, sector reads, error reads
// and readout stepping against the card model
// ==================================================
`timescale 1ns/1ps

module sdcard_tb;
  import sd_pkg::*;

  localparam int busy_timeout = 50000;  // clk cycles allowed per wait

  typedef struct packed {
    sector_t sector;
    logic    exp_error;   // card rejects the read
    int      nbytes;      // bytes stepped through after the read
    logic    poke_next;   // cmd_next sent while busy and ignored
  } read_entry_t;

  logic        clk;
  logic        rst_n;
  sd_cmd_e     command;
  sector_t     sector;
  byte_t       data_out;
  logic        busy;
  logic        read_error;
  logic        sd_cs_n;
  logic        sd_clk;
  logic        sd_mosi;
  logic        sd_miso;
  read_entry_t reads [$];
  logic [31:0] rng_state;

  sdcard #(.clk_div(1)) sdcard_inst (
    .clk(clk), .rst_n(rst_n), .command(command), .sector(sector),
    .data_out(data_out), .busy(busy), .read_error(read_error),
    .sd_cs_n(sd_cs_n), .sd_clk(sd_clk), .sd_mosi(sd_mosi), .sd_miso(sd_miso)
  );

  sd_card_model model_inst (
    .sd_cs_n(sd_cs_n), .sd_clk(sd_clk), .sd_mosi(sd_mosi), .sd_miso(sd_miso)
  );

  bind sdcard sdcard_checker checker_inst (
    .clk(clk), .rst_n(rst_n), .command(command), .busy(busy),
    .sd_cs_n(sd_cs_n), .sd_clk(sd_clk)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // card pattern is the low sector byte plus offset xor 0x5a
  function automatic byte_t expected_byte(input sector_t s, input int i);
    byte_t offset;
    offset = byte_t'(i);
    return (s[7:0] + offset) ^ 8'h5A;
  endfunction

  task automatic check_byte(input byte_t got, input byte_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // outputs are looked at on the falling edge
  task automatic wait_idle(input string what);
    int count;
    count = 0;
    @(negedge clk);
    while (busy && count < busy_timeout) begin
      count = count + 1;
      @(negedge clk);
    end
    if (busy) begin
      $display("timeout: busy did not fall %s", what);
      $display("CHECKS FAILED");
      $fatal(1, "wait for busy timed out");
    end
  endtask

  task automatic step_next();
    @(posedge clk);
    command <= cmd_next;
    @(posedge clk);
    command <= cmd_idle;  // index moved on this edge
    @(negedge clk);
  endtask

  task automatic apply_read(input read_entry_t e);
    @(posedge clk);
    sector  <= e.sector;
    command <= cmd_read;
    @(posedge clk);
    command <= e.poke_next ? cmd_next : cmd_idle;
    if (e.poke_next) begin
      repeat (8) @(posedge clk);
      command <= cmd_idle;
    end
    wait_idle($sformatf("after read of sector %h", e.sector));
    check_flag(read_error, e.exp_error, $sformatf("read_error for sector %h", e.sector));
    if (!e.exp_error) begin
      for (int i = 0; i < e.nbytes; i++) begin
        check_byte(data_out, expected_byte(e.sector, i),
                   $sformatf("byte %0d of sector %h", i, e.sector));
        step_next();
      end
      // 512 steps wrap back to byte 0
      check_byte(data_out, expected_byte(e.sector, e.nbytes),
                 $sformatf("byte after %0d steps of sector %h", e.nbytes, e.sector));
    end
  endtask

  initial begin
    command   = cmd_idle;
    sector    = '0;
    rst_n     = 1'b0;
    rng_state = 32'd23;
    repeat (3) @(posedge clk);
    @(negedge clk);
    // pins and flags while reset is held
    check_flag(busy, 1'b1, "busy in reset");
    check_flag(read_error, 1'b0, "read_error in reset");
    check_flag(sd_cs_n, 1'b1, "sd_cs_n in reset");
    check_flag(sd_clk, 1'b0, "sd_clk in reset");
    check_flag(sd_mosi, 1'b1, "sd_mosi in reset");
    @(posedge clk);
    rst_n <= 1'b1;
    wait_idle("after reset");
    check_flag(read_error, 1'b0, "read_error after init");

    //                sector         error  nbytes  poke
    reads.push_back({32'h0000_0007, 1'b0, 32'd512, 1'b0});
    reads.push_back({32'h0100_0000, 1'b1, 32'd0,   1'b0});
    reads.push_back({32'h00AB_CD12, 1'b0, 32'd16,  1'b0});
    reads.push_back({32'hFFFF_FFFF, 1'b1, 32'd0,   1'b0});
    reads.push_back({32'h0000_0100, 1'b0, 32'd4,   1'b1});
    for (int n = 0; n < 4; n++) begin
      rng_state = next_random(rng_state);
      reads.push_back({rng_state & 32'h00FF_FFFF, 1'b0, 32'd8, n[0]});
    end

    foreach (reads[n]) begin
      apply_read(reads[n]);
    end

    if (sdcard_inst.checker_inst.fail_count != 0) begin
      $display("bound assertions reported %0d failures",
               sdcard_inst.checker_inst.fail_count);
      $display("CHECKS FAILED");
      $fatal(1, "assertion failures");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

// File: sdcard.f
hdl/sd_pkg.sv
hdl/sd_cmd_decode.sv
hdl/sd_spi_engine.sv
hdl/sd_sector_buffer.sv
hdl/sdcard.sv
tb/sd_card_model.sv
tb/sdcard_checker.sv
tb/sdcard_tb.sv

// File: Makefile
# Verilator build for the SD sector reader testbench
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = sdcard_tb
FILELIST  = sdcard.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = ALL CHECKS PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
